// File: Bender.yml
package:
  name: csr_stage

sources:
  - common/csr_pkg.sv
  - csr_stage/csr_access.sv
  - csr_stage/trap_ctrl.sv
  - csr_stage/csr_commit.sv
  - csr_stage/csr_stage.sv
  - target: simulation
    files:
      - testbench/tb_csr_stage.sv

// File: common/csr_pkg.sv
package csr_pkg;

    // One data word of the core
    typedef logic [31:0] xlen_t;

    // CSR address
    // Bits 11:10 == 3 mark read-only, bits 9:8 give the lowest privilege
    typedef logic [11:0] csr_addr_t;

    // Only M and U are implemented
    typedef enum logic [1:0] {
        mode_user    = 2'd0,
        mode_machine = 2'd3
    } priv_mode_e;

    // Stage command
    typedef enum logic [2:0] {
        cmd_none  = 3'd0,
        cmd_write = 3'd1,
        cmd_set   = 3'd2,
        cmd_clear = 3'd3,
        cmd_ecall = 3'd4,
        cmd_mret  = 3'd5
    } csr_cmd_e;

    // mtvec seen as a raw word or as base plus mode
    typedef union packed {
        xlen_t raw;
        struct packed {
            logic [29:0] base;
            logic [1:0]  mode;
        } f;
    } tvec_u;

    // Vectored mtvec mode where 0 is direct
    localparam logic [1:0] tvec_vectored = 2'd1;

    // Implemented machine CSRs
    localparam csr_addr_t addr_mstatus  = 12'h300;
    localparam csr_addr_t addr_mie      = 12'h304;
    localparam csr_addr_t addr_mtvec    = 12'h305;
    localparam csr_addr_t addr_mscratch = 12'h340;
    localparam csr_addr_t addr_mepc     = 12'h341;
    localparam csr_addr_t addr_mcause   = 12'h342;
    localparam csr_addr_t addr_mip      = 12'h344;

    // Exception causes
    localparam xlen_t cause_ecall_u = 32'd8;
    localparam xlen_t cause_ecall_m = 32'd11;

    // Interrupt causes carry bit 31
    localparam xlen_t cause_m_timer = 32'h8000_0007;

    // mstatus fields
    localparam int mstatus_mie_bit  = 3;
    localparam int mstatus_mpie_bit = 7;
    // MPP occupies two bits from here
    localparam int mstatus_mpp_lsb  = 11;

    // Timer enable and pending positions
    localparam int mie_mtie_bit = 7;
    localparam int mip_mtip_bit = 7;

endpackage

// File: csr_stage/csr_access.sv
`timescale 1ns/10ps

module csr_access (
    input  csr_pkg::csr_cmd_e      req_cmd,
    input  csr_pkg::csr_addr_t     req_addr,
    input  csr_pkg::xlen_t         req_operand,
    input  csr_pkg::priv_mode_e    mode,
    input  csr_pkg::xlen_t         mstatus,
    input  csr_pkg::xlen_t         mie,
    input  csr_pkg::xlen_t         mtvec,
    input  csr_pkg::xlen_t         mscratch,
    input  csr_pkg::xlen_t         mepc,
    input  csr_pkg::xlen_t         mcause,
    input  csr_pkg::xlen_t         mip,
    output csr_pkg::xlen_t         old_value,
    output logic                   access_ok,
    output logic                   write_en,
    output csr_pkg::csr_addr_t     write_addr,
    output csr_pkg::xlen_t         new_value
);

    logic           is_rmw;
    logic           priv_ok;
    logic           read_only;
    logic           hit;
    csr_pkg::xlen_t map_value;

    // Only write, set and clear touch a CSR
    assign is_rmw = (req_cmd == csr_pkg::cmd_write) ||
                    (req_cmd == csr_pkg::cmd_set)   ||
                    (req_cmd == csr_pkg::cmd_clear);

    // Address privilege field against current mode
    assign priv_ok = (req_addr[9:8] <= mode);

    // Top two bits set, or mip which only mirrors the timer
    assign read_only = (req_addr[11:10] == 2'b11) || (req_addr == csr_pkg::addr_mip);

    // Implemented map where anything else reads 0
    always_comb begin
        hit       = 1'b1;
        map_value = '0;
        case (req_addr)
            csr_pkg::addr_mstatus:  map_value = mstatus;
            csr_pkg::addr_mie:      map_value = mie;
            csr_pkg::addr_mtvec:    map_value = mtvec;
            csr_pkg::addr_mscratch: map_value = mscratch;
            csr_pkg::addr_mepc:     map_value = mepc;
            csr_pkg::addr_mcause:   map_value = mcause;
            csr_pkg::addr_mip:      map_value = mip;
            default:                hit = 1'b0;
        endcase
    end

    assign access_ok = is_rmw && priv_ok;

    // Denied accesses read as zero
    assign old_value = access_ok ? map_value : '0;

    // Read-modify-write result
    always_comb begin
        case (req_cmd)
            csr_pkg::cmd_set:   new_value = old_value | req_operand;
            csr_pkg::cmd_clear: new_value = old_value & ~req_operand;
            default:            new_value = req_operand;
        endcase
    end

    // Unknown and read-only addresses drop the write
    assign write_en   = access_ok && hit && !read_only;
    assign write_addr = req_addr;

endmodule

// File: csr_stage/csr_commit.sv
`timescale 1ns/10ps

module csr_commit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req_valid,
    input  csr_pkg::xlen_t         req_pc,
    input  csr_pkg::csr_cmd_e      req_cmd,
    input  logic                   mtip,
    input  csr_pkg::xlen_t         old_value,
    input  logic                   access_ok,
    input  logic                   write_en,
    input  csr_pkg::csr_addr_t     write_addr,
    input  csr_pkg::xlen_t         new_value,
    input  logic                   trap_take,
    input  logic                   trap_is_return,
    input  csr_pkg::xlen_t         trap_cause,
    input  csr_pkg::xlen_t         trap_vector,
    output csr_pkg::xlen_t         mstatus,
    output csr_pkg::xlen_t         mie,
    output csr_pkg::tvec_u         mtvec,
    output csr_pkg::xlen_t         mscratch,
    output csr_pkg::xlen_t         mepc,
    output csr_pkg::xlen_t         mcause,
    output csr_pkg::xlen_t         mip,
    output csr_pkg::priv_mode_e    mode,
    output logic                   rsp_valid,
    output csr_pkg::xlen_t         rsp_rdata,
    output logic                   rsp_trap,
    output csr_pkg::xlen_t         rsp_vector
);

    // mstatus fields kept individually
    logic                status_mie;
    logic                status_mpie;
    csr_pkg::priv_mode_e status_mpp;
    logic                mtie;
    logic                sw_write;

    // Software write only when no trap or return claims the cycle
    assign sw_write = req_valid && write_en && !trap_take && !trap_is_return;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode        <= csr_pkg::mode_machine;
            status_mie  <= 1'b0;
            status_mpie <= 1'b0;
            status_mpp  <= csr_pkg::mode_user;
            mtie        <= 1'b0;
            mtvec       <= '0;
            mscratch    <= '0;
            mepc        <= '0;
            mcause      <= '0;
        end else if (trap_take) begin
            // Enter machine mode and stack the interrupt enable
            mepc        <= {req_pc[31:2], 2'b00};
            mcause      <= trap_cause;
            status_mpie <= status_mie;
            status_mie  <= 1'b0;
            status_mpp  <= mode;
            mode        <= csr_pkg::mode_machine;
        end else if (trap_is_return) begin
            // Pop the stack and leave the lowest mode in MPP
            mode        <= status_mpp;
            status_mie  <= status_mpie;
            status_mpie <= 1'b1;
            status_mpp  <= csr_pkg::mode_user;
        end else if (sw_write) begin
            case (write_addr)
                csr_pkg::addr_mstatus: begin
                    status_mie  <= new_value[csr_pkg::mstatus_mie_bit];
                    status_mpie <= new_value[csr_pkg::mstatus_mpie_bit];
                    // MPP holds legal modes only so 1 and 2 fold to user
                    status_mpp  <= (new_value[csr_pkg::mstatus_mpp_lsb +: 2] == 2'b11) ?
                                   csr_pkg::mode_machine : csr_pkg::mode_user;
                end
                csr_pkg::addr_mie:      mtie <= new_value[csr_pkg::mie_mtie_bit];
                csr_pkg::addr_mtvec:    mtvec.raw <= new_value;
                csr_pkg::addr_mscratch: mscratch <= new_value;
                // Instruction alignment
                csr_pkg::addr_mepc:     mepc <= {new_value[31:2], 2'b00};
                csr_pkg::addr_mcause:   mcause <= new_value;
                default: begin
                end
            endcase
        end
    end

    // Word views for the access mux
    always_comb begin
        mstatus = '0;
        mstatus[csr_pkg::mstatus_mie_bit]        = status_mie;
        mstatus[csr_pkg::mstatus_mpie_bit]       = status_mpie;
        mstatus[csr_pkg::mstatus_mpp_lsb +: 2]   = status_mpp;
        mie = '0;
        mie[csr_pkg::mie_mtie_bit] = mtie;
        mip = '0;
        mip[csr_pkg::mip_mtip_bit] = mtip;
    end

    // Response control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
            rsp_trap  <= 1'b0;
        end else begin
            rsp_valid <= req_valid;
            rsp_trap  <= req_valid && (trap_take || trap_is_return);
        end
    end

    // Response payload carries the old value unless a trap took the cycle
    always_ff @(posedge clk) begin
        rsp_rdata  <= (access_ok && !trap_take) ? old_value : '0;
        rsp_vector <= trap_vector;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        mode inside {csr_pkg::mode_user, csr_pkg::mode_machine});

    assert property (@(posedge clk) disable iff (!rst_n) rsp_trap |-> rsp_valid);

    // A return decided upstream must come from an mret request
    assert property (@(posedge clk) disable iff (!rst_n)
        trap_is_return |-> (req_cmd == csr_pkg::cmd_mret));

endmodule

// File: csr_stage/csr_stage.sv
`timescale 1ns/10ps

module csr_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req_valid,
    input  csr_pkg::csr_cmd_e      req_cmd,
    input  csr_pkg::csr_addr_t     req_addr,
    input  csr_pkg::xlen_t         req_operand,
    input  csr_pkg::xlen_t         req_pc,
    input  logic [63:0]            mtime,
    input  logic [63:0]            mtimecmp,
    output logic                   rsp_valid,
    output csr_pkg::xlen_t         rsp_rdata,
    output logic                   rsp_trap,
    output csr_pkg::xlen_t         rsp_vector,
    output csr_pkg::priv_mode_e    mode
);

    // Architectural state views from the commit block
    csr_pkg::xlen_t     mstatus;
    csr_pkg::xlen_t     mie;
    csr_pkg::tvec_u     mtvec;
    csr_pkg::xlen_t     mscratch;
    csr_pkg::xlen_t     mepc;
    csr_pkg::xlen_t     mcause;
    csr_pkg::xlen_t     mip;

    // Registered timer pending
    logic               mtip;

    // Access results
    csr_pkg::xlen_t     old_value;
    logic               access_ok;
    logic               write_en;
    csr_pkg::csr_addr_t write_addr;
    csr_pkg::xlen_t     new_value;

    // Trap results
    logic               trap_take;
    logic               trap_is_return;
    csr_pkg::xlen_t     trap_cause;
    csr_pkg::xlen_t     trap_vector;

    // Register access path
    csr_access csr_access_inst (
        .req_cmd     (req_cmd),
        .req_addr    (req_addr),
        .req_operand (req_operand),
        .mode        (mode),
        .mstatus     (mstatus),
        .mie         (mie),
        .mtvec       (mtvec.raw),
        .mscratch    (mscratch),
        .mepc        (mepc),
        .mcause      (mcause),
        .mip         (mip),
        .old_value   (old_value),
        .access_ok   (access_ok),
        .write_en    (write_en),
        .write_addr  (write_addr),
        .new_value   (new_value)
    );

    // Trap decision running alongside the access
    trap_ctrl trap_ctrl_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .mtime          (mtime),
        .mtimecmp       (mtimecmp),
        .req_valid      (req_valid),
        .req_cmd        (req_cmd),
        .mode           (mode),
        .mstatus_mie    (mstatus[csr_pkg::mstatus_mie_bit]),
        .mie_mtie       (mie[csr_pkg::mie_mtie_bit]),
        .mtvec          (mtvec),
        .mepc           (mepc),
        .mtip           (mtip),
        .trap_take      (trap_take),
        .trap_is_return (trap_is_return),
        .trap_cause     (trap_cause),
        .trap_vector    (trap_vector)
    );

    // State owner and response register
    csr_commit csr_commit_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid      (req_valid),
        .req_pc         (req_pc),
        .req_cmd        (req_cmd),
        .mtip           (mtip),
        .old_value      (old_value),
        .access_ok      (access_ok),
        .write_en       (write_en),
        .write_addr     (write_addr),
        .new_value      (new_value),
        .trap_take      (trap_take),
        .trap_is_return (trap_is_return),
        .trap_cause     (trap_cause),
        .trap_vector    (trap_vector),
        .mstatus        (mstatus),
        .mie            (mie),
        .mtvec          (mtvec),
        .mscratch       (mscratch),
        .mepc           (mepc),
        .mcause         (mcause),
        .mip            (mip),
        .mode           (mode),
        .rsp_valid      (rsp_valid),
        .rsp_rdata      (rsp_rdata),
        .rsp_trap       (rsp_trap),
        .rsp_vector     (rsp_vector)
    );

endmodule

// File: csr_stage/trap_ctrl.sv
`timescale 1ns/10ps

module trap_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [63:0]            mtime,
    input  logic [63:0]            mtimecmp,
    input  logic                   req_valid,
    input  csr_pkg::csr_cmd_e      req_cmd,
    input  csr_pkg::priv_mode_e    mode,
    input  logic                   mstatus_mie,
    input  logic                   mie_mtie,
    input  csr_pkg::tvec_u         mtvec,
    input  csr_pkg::xlen_t         mepc,
    output logic                   mtip,
    output logic                   trap_take,
    output logic                   trap_is_return,
    output csr_pkg::xlen_t         trap_cause,
    output csr_pkg::xlen_t         trap_vector
);

    logic           mtip_q;
    logic           irq;
    logic           ecall;
    csr_pkg::xlen_t vec_base;
    csr_pkg::xlen_t vec_offset;

    // Timer compare registered one cycle ahead of the pending bit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtip_q <= 1'b0;
        end else begin
            mtip_q <= (mtime >= mtimecmp);
        end
    end

    assign mtip = mtip_q;

    // Pending and enabled both globally and locally
    assign irq   = req_valid && mtip_q && mstatus_mie && mie_mtie;
    assign ecall = req_valid && (req_cmd == csr_pkg::cmd_ecall);

    // Interrupt wins over whatever command came with it
    assign trap_take      = irq || ecall;
    assign trap_is_return = req_valid && !irq && (req_cmd == csr_pkg::cmd_mret);

    // ecall cause follows the mode it came from
    assign trap_cause = irq ? csr_pkg::cause_m_timer :
                        (mode == csr_pkg::mode_user) ? csr_pkg::cause_ecall_u :
                                                       csr_pkg::cause_ecall_m;

    // Base with the mode bits dropped
    assign vec_base = {mtvec.f.base, 2'b00};

    // Vectored mode adds four times the code for interrupts only
    assign vec_offset = (irq && (mtvec.f.mode == csr_pkg::tvec_vectored)) ?
                        {trap_cause[29:0], 2'b00} : '0;

    assign trap_vector = trap_is_return ? mepc :
                         trap_take      ? vec_base + vec_offset : '0;

    // A trap and a return in the same request would race on mode
    assert property (@(posedge clk) disable iff (!rst_n) !(trap_take && trap_is_return));

endmodule

// File: sim.f
common/csr_pkg.sv
csr_stage/csr_access.sv
csr_stage/trap_ctrl.sv
csr_stage/csr_commit.sv
csr_stage/csr_stage.sv
testbench/tb_csr_stage.sv

// File: testbench/csr_stimulus.txt
# cmd addr operand pc mtime mtimecmp exp_rdata exp_trap exp_vector exp_mode (all hex)
# cmd 1 write, 2 set, 3 clear, 4 ecall, 5 mret, 0 none; timer compare lands one request later
1 340 12345678 0 0 ffffffffffffffff 00000000 0 00000000 3
2 340 0000ff00 0 0 ffffffffffffffff 12345678 0 00000000 3
3 340 00000078 0 0 ffffffffffffffff 1234ff78 0 00000000 3
2 340 00000000 0 0 ffffffffffffffff 1234ff00 0 00000000 3
1 305 00001000 0 0 ffffffffffffffff 00000000 0 00000000 3
2 305 00000001 0 0 ffffffffffffffff 00001000 0 00000000 3
3 305 00000001 0 0 ffffffffffffffff 00001001 0 00000000 3
1 341 00002003 0 0 ffffffffffffffff 00000000 0 00000000 3
2 341 00000000 0 0 ffffffffffffffff 00002000 0 00000000 3
1 344 ffffffff 0 0 ffffffffffffffff 00000000 0 00000000 3
1 300 00000080 0 0 ffffffffffffffff 00000000 0 00000000 3
2 300 00000000 0 0 ffffffffffffffff 00000080 0 00000000 3
5 000 00000000 0 0 ffffffffffffffff 00000000 1 00002000 0
1 340 deadbeef 0 0 ffffffffffffffff 00000000 0 00000000 0
2 340 00000000 0 0 ffffffffffffffff 00000000 0 00000000 0
4 000 00000000 3004 0 ffffffffffffffff 00000000 1 00001000 3
2 340 00000000 0 0 ffffffffffffffff 1234ff00 0 00000000 3
2 342 00000000 0 0 ffffffffffffffff 00000008 0 00000000 3
2 341 00000000 0 0 ffffffffffffffff 00003004 0 00000000 3
2 300 00000000 0 0 ffffffffffffffff 00000080 0 00000000 3
4 000 00000000 4008 0 ffffffffffffffff 00000000 1 00001000 3
2 342 00000000 0 0 ffffffffffffffff 0000000b 0 00000000 3
2 341 00000000 0 0 ffffffffffffffff 00004008 0 00000000 3
2 300 00000000 0 0 ffffffffffffffff 00001800 0 00000000 3
2 304 00000080 0 0 ffffffffffffffff 00000000 0 00000000 3
2 305 00000001 0 0 ffffffffffffffff 00001000 0 00000000 3
2 300 00000008 0 0 ffffffffffffffff 00001800 0 00000000 3
2 340 00000000 0 100 80 1234ff00 0 00000000 3
1 340 55555555 5010 100 80 00000000 1 0000101c 3
2 340 00000000 0 100 80 1234ff00 0 00000000 3
2 342 00000000 0 100 80 80000007 0 00000000 3
2 344 00000000 0 100 80 00000080 0 00000000 3
2 341 00000000 0 100 80 00005010 0 00000000 3
2 300 00000008 0 40 80 00001880 0 00000000 3
2 340 00000000 0 40 80 1234ff00 0 00000000 3
0 340 00000000 0 40 80 00000000 0 00000000 3

// File: testbench/tb_csr_stage.sv
`timescale 1ns/10ps

module tb_csr_stage;

    // Galois feedback mask for x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] lfsr_taps = 32'h8020_0003;

    logic                clk;
    logic                rst_n;
    logic                req_valid;
    csr_pkg::csr_cmd_e   req_cmd;
    csr_pkg::csr_addr_t  req_addr;
    csr_pkg::xlen_t      req_operand;
    csr_pkg::xlen_t      req_pc;
    logic [63:0]         mtime;
    logic [63:0]         mtimecmp;
    logic                rsp_valid;
    csr_pkg::xlen_t      rsp_rdata;
    logic                rsp_trap;
    csr_pkg::xlen_t      rsp_vector;
    csr_pkg::priv_mode_e mode;

    // One entry per stimulus line
    logic [2:0]  line_cmd[$];
    logic [11:0] line_addr[$];
    logic [31:0] line_operand[$];
    logic [31:0] line_pc[$];
    logic [63:0] line_mtime[$];
    logic [63:0] line_mtimecmp[$];
    logic [31:0] exp_rdata[$];
    logic        exp_trap[$];
    logic [31:0] exp_vector[$];
    logic [1:0]  exp_mode[$];

    logic [31:0] lfsr_state;
    int          current_line = 0;
    int          cycle_count = 0;
    int          cycle_limit = 1000;

    csr_stage csr_stage_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .req_cmd     (req_cmd),
        .req_addr    (req_addr),
        .req_operand (req_operand),
        .req_pc      (req_pc),
        .mtime       (mtime),
        .mtimecmp    (mtimecmp),
        .rsp_valid   (rsp_valid),
        .rsp_rdata   (rsp_rdata),
        .rsp_trap    (rsp_trap),
        .rsp_vector  (rsp_vector),
        .mode        (mode)
    );

    // 40 ns period
    initial clk = 1'b0;
    always #20 clk = ~clk;

    // Watchdog with its limit set once the stimulus length is known
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: run passed %0d cycles before the stimulus finished", cycle_limit);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ lfsr_taps;
        end else begin
            return state >> 1;
        end
    endfunction

    // Two LFSR bits give an idle gap of 0 to 3 cycles
    task automatic draw_gap(output int gap);
        int bit_idx;
        gap = 0;
        for (bit_idx = 0; bit_idx < 2; bit_idx++) begin
            gap = (gap << 1) | lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic check_word(input string name, input csr_pkg::xlen_t expected,
                              input csr_pkg::xlen_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %s expected %h actual %h (line %0d)",
                     name, expected, actual, current_line);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[FAIL] %s expected %h actual %h (line %0d)",
                     name, expected, actual, current_line);
            abort_run();
        end
    endtask

    task automatic check_mode(input string name, input csr_pkg::priv_mode_e expected,
                              input csr_pkg::priv_mode_e actual);
        if (actual !== expected) begin
            $display("[FAIL] %s expected %h actual %h (line %0d)",
                     name, expected, actual, current_line);
            abort_run();
        end
    endtask

    // Comment lines start with # and every other line holds ten hex fields
    task automatic load_stimulus();
        int          fd;
        int          got;
        int          fields;
        string       text;
        logic [31:0] cmd_v;
        logic [31:0] addr_v;
        logic [31:0] operand_v;
        logic [31:0] pc_v;
        logic [63:0] mtime_v;
        logic [63:0] cmp_v;
        logic [31:0] rdata_v;
        logic [31:0] trap_v;
        logic [31:0] vector_v;
        logic [31:0] mode_v;
        fd = $fopen("testbench/csr_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open testbench/csr_stimulus.txt for reading");
            abort_run();
        end
        while (!$feof(fd)) begin
            text = "";
            got = $fgets(text, fd);
            if (got > 1 && text[0] != "#") begin
                fields = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h", cmd_v, addr_v,
                                 operand_v, pc_v, mtime_v, cmp_v, rdata_v, trap_v,
                                 vector_v, mode_v);
                if (fields != 10) begin
                    $display("Stimulus line does not hold ten fields: %s", text);
                    abort_run();
                end
                line_cmd.push_back(cmd_v[2:0]);
                line_addr.push_back(addr_v[11:0]);
                line_operand.push_back(operand_v);
                line_pc.push_back(pc_v);
                line_mtime.push_back(mtime_v);
                line_mtimecmp.push_back(cmp_v);
                exp_rdata.push_back(rdata_v);
                exp_trap.push_back(trap_v[0]);
                exp_vector.push_back(vector_v);
                exp_mode.push_back(mode_v[1:0]);
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_request(input int idx);
        req_valid   <= 1'b1;
        req_cmd     <= csr_pkg::csr_cmd_e'(line_cmd[idx]);
        req_addr    <= line_addr[idx];
        req_operand <= line_operand[idx];
        req_pc      <= line_pc[idx];
        mtime       <= line_mtime[idx];
        mtimecmp    <= line_mtimecmp[idx];
    endtask

    // Timer inputs keep the last line's values
    task automatic drive_idle();
        req_valid <= 1'b0;
        req_cmd   <= csr_pkg::cmd_none;
    endtask

    task automatic check_response(input int idx);
        current_line = idx + 1;
        check_flag("rsp_valid", 1'b1, rsp_valid);
        check_word("rsp_rdata", exp_rdata[idx], rsp_rdata);
        check_flag("rsp_trap", exp_trap[idx], rsp_trap);
        check_word("rsp_vector", exp_vector[idx], rsp_vector);
        check_mode("mode", csr_pkg::priv_mode_e'(exp_mode[idx]), mode);
    endtask

    initial begin
        int idx;
        int gap;
        rst_n       = 1'b0;
        req_valid   = 1'b0;
        req_cmd     = csr_pkg::cmd_none;
        req_addr    = '0;
        req_operand = '0;
        req_pc      = '0;
        mtime       = '0;
        mtimecmp    = '1;
        lfsr_state  = 32'hc88ea39e;
        load_stimulus();
        if (line_cmd.size() == 0) begin
            $display("Stimulus file holds no transactions");
            abort_run();
        end
        cycle_limit = line_cmd.size() * 5 + 40;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        drive_request(0);
        for (idx = 0; idx < line_cmd.size(); idx++) begin
            // Accepting edge of this request
            @(posedge clk);
            drive_idle();
            draw_gap(gap);
            // Back to back requests go in while this one responds
            if (idx + 1 < line_cmd.size() && gap == 0) begin
                drive_request(idx + 1);
            end
            // Response is stable away from the edges
            @(negedge clk);
            check_response(idx);
            if (idx + 1 < line_cmd.size() && gap > 0) begin
                repeat (gap) @(posedge clk);
                drive_request(idx + 1);
            end
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule
